// ==== common/core_cfg.svh ====
// Core-wide sizes, reset vector and RV32I major opcodes
// Include wherever a width or an opcode value is needed

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath sizes
`define CORE_XLEN        32           // Data and address width
`define CORE_REG_ADDR_W  5            // GPR index width
`define CORE_NUM_REGS    32           // x0..x31, x0 hardwired

`define CORE_RESET_PC    32'h0000_0000 // First fetch address

// Major opcodes kept by this core
`define CORE_OPC_OP      7'b0110011   // Reg-reg ALU
`define CORE_OPC_OP_IMM  7'b0010011   // Reg-imm ALU
`define CORE_OPC_LUI     7'b0110111
`define CORE_OPC_AUIPC   7'b0010111

`endif

// ==== common/core_pkg.sv ====
// Shared types of the five-stage integer core
// Stage registers, writeback bus and instruction views

`default_nettype none

`include "core_cfg.svh"

package core_pkg;

  // --------------------
  // Instruction word
  // --------------------
  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`CORE_REG_ADDR_W-1:0] rs2;
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [2:0]                  funct3;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [6:0]                  opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]                 imm12;  // Sign bit on top
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [2:0]                  funct3;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [6:0]                  opcode;
  } i_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_u;

  // ALU micro-ops
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B                                   // LUI
  } alu_op_e;

  // Take-writeback bits per operand and stage
  typedef struct packed {
    logic id_a;
    logic is_a;
    logic ex_a;
    logic id_b;
    logic is_b;
    logic ex_b;
  } fwd_sel_t;

  // --------------------
  // Stage registers
  // --------------------
  typedef struct packed {
    logic [`CORE_XLEN-1:0] pc;
    instr_u                instr;
  } if_id_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]       pc;
    logic [`CORE_XLEN-1:0]       rs1_data;
    logic [`CORE_XLEN-1:0]       rs2_data;
    logic [`CORE_XLEN-1:0]       imm;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic                        writes_rd;  // Also low for rd == x0
    logic                        use_pc_a;   // AUIPC
    logic                        use_imm_b;
    alu_op_e                     alu_op;
    logic                        is_fwd_a;
    logic                        is_fwd_b;
    logic                        ex_fwd_a;
    logic                        ex_fwd_b;
  } id_is_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]       pc;
    logic [`CORE_XLEN-1:0]       a;
    logic [`CORE_XLEN-1:0]       b;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic                        writes_rd;
    alu_op_e                     alu_op;
    logic                        ex_fwd_a;
    logic                        ex_fwd_b;
  } is_ex_t;

  // Writeback and forward bus, also the core output
  typedef struct packed {
    logic                        valid;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [`CORE_XLEN-1:0]       data;
    logic [`CORE_XLEN-1:0]       pc;    // Retiring PC
  } wb_t;

endpackage

`default_nettype wire

// ==== hw/fetch_unit.sv ====
// Instruction fetch stage
// PC steps by 4 every cycle, fetched word and PC land in IF/ID

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module fetch_unit (
  input  logic                  clock_in,
  input  logic                  rst_n,
  input  core_pkg::instr_u      imem_data,  // Combinational read data
  output logic [`CORE_XLEN-1:0] imem_addr,
  output core_pkg::if_id_t      if_id
);

  localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

  logic [`CORE_XLEN-1:0] pc;

  assign imem_addr = pc;  // No redirect, PC goes straight out

  always_ff @(posedge clock_in or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= `CORE_RESET_PC;
      if_id <= '0;                 // Opcode 0 is a bubble
    end else begin
      pc          <= pc + PC_STEP;
      if_id.pc    <= pc;
      if_id.instr <= imem_data;
    end
  end

  // PC never leaves word alignment once running
  a_pc_aligned: assert property (@(posedge clock_in) disable iff (!rst_n)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/decode/gpr_file.sv ====
// Integer register file, x1..x31
// Two combinational read ports, write port fed by the writeback bus

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module gpr_file (
  input  logic                         clock_in,
  input  logic                         rst_n,
  input  logic [`CORE_REG_ADDR_W-1:0]  rs1_addr,
  input  logic [`CORE_REG_ADDR_W-1:0]  rs2_addr,
  output logic [`CORE_XLEN-1:0]        rs1_data,
  output logic [`CORE_XLEN-1:0]        rs2_data,
  input  core_pkg::wb_t                wb
);

  logic [`CORE_XLEN-1:0] regs [1:`CORE_NUM_REGS-1];  // No storage for x0

  // Write at the end of the WB cycle
  always_ff @(posedge clock_in or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hw/decode/decode_stage.sv ====
// Decode stage with GPR read and forward compare
// Selects for IS and EX forwarding are produced here and travel down

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
  input  logic             clock_in,
  input  logic             rst_n,
  input  core_pkg::if_id_t if_id,
  input  core_pkg::id_is_t id_is_fb,  // Distance 1 producer
  input  core_pkg::is_ex_t is_ex_fb,  // Distance 2 producer
  input  core_pkg::wb_t    wb,        // Distance 3 producer
  output core_pkg::id_is_t id_is
);
  import core_pkg::*;

  instr_u                ins;
  logic [`CORE_XLEN-1:0] gpr_rs1;
  logic [`CORE_XLEN-1:0] gpr_rs2;
  logic [`CORE_XLEN-1:0] rs1_val;
  logic [`CORE_XLEN-1:0] rs2_val;
  logic [`CORE_XLEN-1:0] imm;
  logic [`CORE_XLEN-1:0] u_imm;
  alu_op_e               alu_op;
  logic                  supported;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  use_pc_a;
  logic                  use_imm_b;
  logic                  writes_rd;
  fwd_sel_t              fwd;

  // funct3 map shared by OP and OP-IMM
  function automatic alu_op_e f3_op(input logic [2:0] f3, input logic sub, input logic sra);
    case (f3)
      3'b000:  return sub ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return sra ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign ins   = if_id.instr;
  assign u_imm = {ins.r.funct7, ins.r.rs2, ins.r.rs1, ins.r.funct3, 12'b0};  // Upper 20 bits

  gpr_file gpr0 (
    .clock_in (clock_in),
    .rst_n    (rst_n),
    .rs1_addr (ins.r.rs1),
    .rs2_addr (ins.r.rs2),
    .rs1_data (gpr_rs1),
    .rs2_data (gpr_rs2),
    .wb       (wb)
  );

  // --------------------
  // Opcode decode
  // --------------------
  always_comb begin
    alu_op    = ALU_ADD;
    supported = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    use_pc_a  = 1'b0;
    use_imm_b = 1'b0;
    imm       = '0;
    case (ins.r.opcode)
      `CORE_OPC_OP: begin
        supported = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        alu_op    = f3_op(ins.r.funct3, ins.r.funct7[5], ins.r.funct7[5]);
      end
      `CORE_OPC_OP_IMM: begin
        supported = 1'b1;
        uses_rs1  = 1'b1;
        use_imm_b = 1'b1;
        imm       = {{(`CORE_XLEN-12){ins.i.imm12[11]}}, ins.i.imm12};
        alu_op    = f3_op(ins.i.funct3, 1'b0, ins.i.imm12[10]);  // No SUBI
      end
      `CORE_OPC_LUI: begin
        supported = 1'b1;
        use_imm_b = 1'b1;
        imm       = u_imm;
        alu_op    = ALU_PASS_B;
      end
      `CORE_OPC_AUIPC: begin
        supported = 1'b1;
        use_pc_a  = 1'b1;
        use_imm_b = 1'b1;
        imm       = u_imm;
      end
      default: ;  // Unsupported, flows through as a bubble
    endcase
  end

  assign writes_rd = supported && (ins.r.rd != '0);  // x0 writes dropped here

  // Nearest older producer wins since later stages substitute last
  always_comb begin
    fwd.ex_a = uses_rs1 && id_is_fb.writes_rd && (id_is_fb.rd == ins.r.rs1);
    fwd.is_a = uses_rs1 && is_ex_fb.writes_rd && (is_ex_fb.rd == ins.r.rs1);
    fwd.id_a = uses_rs1 && wb.valid && (wb.rd == ins.r.rs1);
    fwd.ex_b = uses_rs2 && id_is_fb.writes_rd && (id_is_fb.rd == ins.r.rs2);
    fwd.is_b = uses_rs2 && is_ex_fb.writes_rd && (is_ex_fb.rd == ins.r.rs2);
    fwd.id_b = uses_rs2 && wb.valid && (wb.rd == ins.r.rs2);
  end

  assign rs1_val = fwd.id_a ? wb.data : gpr_rs1;  // ID-level bypass
  assign rs2_val = fwd.id_b ? wb.data : gpr_rs2;

  // ID/IS register
  always_ff @(posedge clock_in or negedge rst_n) begin
    if (!rst_n) begin
      id_is <= '0;
    end else begin
      id_is.pc        <= if_id.pc;
      id_is.rs1_data  <= rs1_val;
      id_is.rs2_data  <= rs2_val;
      id_is.imm       <= imm;
      id_is.rd        <= ins.r.rd;
      id_is.writes_rd <= writes_rd;
      id_is.use_pc_a  <= use_pc_a;
      id_is.use_imm_b <= use_imm_b;
      id_is.alu_op    <= alu_op;
      id_is.is_fwd_a  <= fwd.is_a;
      id_is.is_fwd_b  <= fwd.is_b;
      id_is.ex_fwd_a  <= fwd.ex_a;
      id_is.ex_fwd_b  <= fwd.ex_b;
    end
  end

  // PC or immediate operands must never pick up a forward downstream
  a_no_fwd_pc_a: assert property (@(posedge clock_in) disable iff (!rst_n)
    id_is.use_pc_a |-> !(id_is.is_fwd_a || id_is.ex_fwd_a));
  a_no_fwd_imm_b: assert property (@(posedge clock_in) disable iff (!rst_n)
    id_is.use_imm_b |-> !(id_is.is_fwd_b || id_is.ex_fwd_b));

endmodule

`default_nettype wire

// ==== hw/issue_stage.sv ====
// Issue stage
// IS-level forwarding, operand A/B selection and the IS/EX register

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module issue_stage (
  input  logic             clock_in,
  input  logic             rst_n,
  input  core_pkg::id_is_t id_is,
  input  core_pkg::wb_t    wb,
  output core_pkg::is_ex_t is_ex
);

  logic [`CORE_XLEN-1:0] rs1_val;
  logic [`CORE_XLEN-1:0] rs2_val;
  logic [`CORE_XLEN-1:0] op_a;
  logic [`CORE_XLEN-1:0] op_b;

  // --------------------
  // Operand muxes
  // --------------------
  assign rs1_val = id_is.is_fwd_a ? wb.data : id_is.rs1_data;  // Distance 2 bypass
  assign rs2_val = id_is.is_fwd_b ? wb.data : id_is.rs2_data;

  assign op_a = id_is.use_pc_a  ? id_is.pc  : rs1_val;  // PC for AUIPC
  assign op_b = id_is.use_imm_b ? id_is.imm : rs2_val;

  // IS/EX register
  always_ff @(posedge clock_in or negedge rst_n) begin
    if (!rst_n) begin
      is_ex <= '0;
    end else begin
      is_ex.pc        <= id_is.pc;
      is_ex.a         <= op_a;
      is_ex.b         <= op_b;
      is_ex.rd        <= id_is.rd;
      is_ex.writes_rd <= id_is.writes_rd;
      is_ex.alu_op    <= id_is.alu_op;
      is_ex.ex_fwd_a  <= id_is.ex_fwd_a;  // Resolved one stage later
      is_ex.ex_fwd_b  <= id_is.ex_fwd_b;
    end
  end

endmodule

`default_nettype wire

// ==== hw/exec_stage.sv ====
// Execute stage
// EX-level forwarding from its own output, integer ALU, EX/WB register

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module exec_stage (
  input  logic             clock_in,
  input  logic             rst_n,
  input  core_pkg::is_ex_t is_ex,
  output core_pkg::wb_t    wb
);
  import core_pkg::*;

  logic [`CORE_XLEN-1:0] op_a;
  logic [`CORE_XLEN-1:0] op_b;
  logic [`CORE_XLEN-1:0] result;
  logic [4:0]            shamt;

  // Distance 1 bypass straight from the EX/WB register
  assign op_a  = is_ex.ex_fwd_a ? wb.data : is_ex.a;
  assign op_b  = is_ex.ex_fwd_b ? wb.data : is_ex.b;
  assign shamt = op_b[4:0];  // Low 5 bits only

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (is_ex.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);  // Sign fill
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;                                // LUI
      default:    result = '0;
    endcase
  end

  // EX/WB register, drives GPR write and all bypasses
  always_ff @(posedge clock_in or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb.valid <= is_ex.writes_rd;
      wb.rd    <= is_ex.rd;
      wb.data  <= result;
      wb.pc    <= is_ex.pc;
    end
  end

  // Decode must have filtered x0 destinations
  a_wb_rd_nonzero: assert property (@(posedge clock_in) disable iff (!rst_n)
    wb.valid |-> (wb.rd != '0));

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
// Top of the five-stage RV32I integer core
// Instruction memory sits outside, writeback bus is the only output

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_top (
  input  logic                  clock_in,
  input  logic                  rst_n,
  output logic [`CORE_XLEN-1:0] imem_addr,
  input  core_pkg::instr_u      imem_data,  // Same-cycle read
  output core_pkg::wb_t         wb
);
  import core_pkg::*;

  // Stage boundary registers
  if_id_t if_id;
  id_is_t id_is;
  is_ex_t is_ex;

  fetch_unit fetch0 (
    .clock_in  (clock_in),
    .rst_n     (rst_n),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .if_id     (if_id)
  );

  // IS and EX registers loop back for the forward compare
  decode_stage decode0 (
    .clock_in (clock_in),
    .rst_n    (rst_n),
    .if_id    (if_id),
    .id_is_fb (id_is),
    .is_ex_fb (is_ex),
    .wb       (wb),
    .id_is    (id_is)
  );

  issue_stage issue0 (
    .clock_in (clock_in),
    .rst_n    (rst_n),
    .id_is    (id_is),
    .wb       (wb),
    .is_ex    (is_ex)
  );

  exec_stage exec0 (
    .clock_in (clock_in),
    .rst_n    (rst_n),
    .is_ex    (is_ex),
    .wb       (wb)
  );

endmodule

`default_nettype wire

// ==== verification/tb_core_top.sv ====
// Testbench for the five-stage integer core
// Builds a 64-word program (directed forwarding chains, then xorshift words),
// serves it as a combinational instruction memory and checks every retirement
// against a reference register model through concurrent assertions

`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module tb_core_top;
  import core_pkg::*;

  localparam int          PROG_WORDS  = 64;
  localparam int          CHAIN_WORDS = 16;
  localparam logic [31:0] PROG_BYTES  = 32'd256;
  localparam logic [31:0] CHAIN_BYTES = 32'd64;
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;  // ADDI x0,x0,0
  localparam logic [31:0] SEED        = 32'h962e_1e5e;

  logic        clock_in;
  logic        rst_n;
  logic [31:0] imem_addr;
  instr_u      imem_data;
  wb_t         wb;

  logic [31:0] prog [0:PROG_WORDS-1];
  logic [31:0] ref_regs [0:31];      // Architectural state after retired instructions
  logic [31:0] pc_hist [1:4];        // Fetch addresses of the last four cycles
  int          run_cycles;           // Saturating edge count since reset release
  logic [31:0] ret_pc;               // PC expected in WB this cycle
  logic [31:0] ret_word;
  logic        ret_is_op;
  logic        exp_valid;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  int          err_cnt [1:6];        // Per test
  int          tests_run;
  int          tests_failed;
  bit          ok;

  core_top dut0 (
    .clock_in  (clock_in),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb        (wb)
  );

  // Combinational instruction memory with NOP past the program
  assign imem_data = (imem_addr < PROG_BYTES) ? prog[imem_addr[7:2]] : NOP_WORD;

  initial begin
    clock_in = 1'b0;
    forever #4 clock_in = ~clock_in;
  end

  // --------------------
  // Program generation
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    r = SEED;
    prog[0]  = itype_word(12'h123, 5'd0, 3'b000, 5'd1);          // ADDI x1
    prog[1]  = itype_word(12'h005, 5'd1, 3'b000, 5'd2);          // x1 at distance 1
    prog[2]  = rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);      // ADD at distances 2 and 1
    prog[3]  = rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);      // SUB at distances 3 and 2
    prog[4]  = rtype_word(7'h00, 5'd3, 5'd1, 3'b100, 5'd5);      // XOR at distances 4 and 2
    prog[5]  = utype_word(20'habcde, 5'd6, `CORE_OPC_LUI);
    prog[6]  = rtype_word(7'h00, 5'd4, 5'd6, 3'b110, 5'd7);      // OR at distances 1 and 3
    prog[7]  = utype_word(20'h00012, 5'd1, `CORE_OPC_AUIPC);
    prog[8]  = rtype_word(7'h20, 5'd5, 5'd7, 3'b101, 5'd2);      // SRA by x5
    prog[9]  = rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0);      // Write to x0 dropped
    prog[10] = rtype_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd3);      // x0 read just after
    prog[11] = {20'h00000, 5'd3, 7'b1100011};                    // Unsupported opcode with rd x3
    prog[12] = rtype_word(7'h00, 5'd3, 5'd3, 3'b010, 5'd4);      // SLT
    prog[13] = itype_word(12'hfff, 5'd4, 3'b000, 5'd5);
    prog[14] = itype_word(12'h003, 5'd5, 3'b000, 5'd5);
    prog[15] = rtype_word(7'h00, 5'd5, 5'd5, 3'b000, 5'd6);      // Nearest x5 producer wins
    for (int k = CHAIN_WORDS; k < PROG_WORDS; k++) begin
      r   = xorshift32(r);
      f3  = r[15:13];
      alt = r[16] && (f3 == 3'b000 || f3 == 3'b101);        // SUB or SRA
      rd  = {2'b00, r[6:4]};                                // x0..x7 keep chains dense
      rs1 = {2'b00, r[9:7]};
      case (r[3:0])
        4'd8, 4'd9, 4'd10, 4'd11: begin
          if (f3 == 3'b001 || f3 == 3'b101)
            prog[k] = itype_word({1'b0, alt, 5'b00000, r[21:17]}, rs1, f3, rd);
          else
            prog[k] = itype_word(r[28:17], rs1, f3, rd);
        end
        4'd12:   prog[k] = utype_word(r[31:12], rd, `CORE_OPC_LUI);
        4'd13:   prog[k] = utype_word(r[31:12], rd, `CORE_OPC_AUIPC);
        4'd14:   prog[k] = {r[31:7], r[20] ? 7'b1100011 : 7'b0001111};  // Branch or fence
        default: prog[k] = rtype_word(alt ? 7'h20 : 7'h00, {2'b00, r[12:10]}, rs1, f3, rd);
      endcase
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic logic writes_reg(input logic [31:0] w);
    logic kept;
    kept = (w[6:0] == `CORE_OPC_OP) || (w[6:0] == `CORE_OPC_OP_IMM) ||
           (w[6:0] == `CORE_OPC_LUI) || (w[6:0] == `CORE_OPC_AUIPC);
    return kept && (w[11:7] != 5'd0);
  endfunction

  function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] pc,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rhs;
    logic [31:0] res;
    logic        is_op;
    is_op = (w[6:0] == `CORE_OPC_OP);
    rhs   = is_op ? b : {{20{w[31]}}, w[31:20]};   // I-immediate sign extended
    res   = 32'd0;
    if (w[6:0] == `CORE_OPC_LUI) begin
      res = {w[31:12], 12'h000};
    end else if (w[6:0] == `CORE_OPC_AUIPC) begin
      res = pc + {w[31:12], 12'h000};
    end else begin
      case (w[14:12])
        3'b000:  res = (is_op && w[30]) ? a - rhs : a + rhs;
        3'b001:  res = a << rhs[4:0];
        3'b010:  res = ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
        3'b011:  res = (a < rhs) ? 32'd1 : 32'd0;
        3'b100:  res = a ^ rhs;
        3'b101: begin
          if (w[30])
            res = $signed(a) >>> rhs[4:0];
          else
            res = a >> rhs[4:0];
        end
        3'b110:  res = a | rhs;
        default: res = a & rhs;
      endcase
    end
    return res;
  endfunction

  assign ret_pc    = pc_hist[4];
  assign ret_is_op = (ret_word[6:0] == `CORE_OPC_OP);

  always_comb begin
    ret_word  = (ret_pc < PROG_BYTES) ? prog[ret_pc[7:2]] : NOP_WORD;
    exp_valid = writes_reg(ret_word);
    exp_rd    = ret_word[11:7];
    exp_data  = ref_result(ret_word, ret_pc, ref_regs[ret_word[19:15]],
                           ref_regs[ret_word[24:20]]);
  end

  always_ff @(posedge clock_in or negedge rst_n) begin
    if (!rst_n) begin
      run_cycles <= 0;
      for (int i = 1; i <= 4; i++) pc_hist[i] <= 32'd0;
      for (int i = 0; i < 32; i++) ref_regs[i] <= 32'd0;
    end else begin
      if (run_cycles < 8) run_cycles <= run_cycles + 1;
      pc_hist[1] <= imem_addr;
      for (int i = 2; i <= 4; i++) pc_hist[i] <= pc_hist[i-1];
      if (run_cycles >= 4 && exp_valid) ref_regs[exp_rd] <= exp_data;  // Retire into the model
    end
  end

  // --------------------
  // Checks
  // --------------------
  task automatic note_fail(input int num, input string what, input logic [31:0] pc,
                           input logic [31:0] got, input logic [31:0] want);
    err_cnt[num]++;
    $display("Fail %0t: %s at pc 0x%08h, got 0x%08h, expected 0x%08h",
             $time, what, pc, got, want);
  endtask

  a_reset_valid: assert property (@(posedge clock_in)
    (!rst_n || run_cycles == 0) |-> !wb.valid)
    else note_fail(1, "wb.valid in reset", 32'd0, {31'd0, $sampled(wb.valid)}, 32'd0);
  a_reset_addr: assert property (@(posedge clock_in)
    (!rst_n || run_cycles == 0) |-> (imem_addr == `CORE_RESET_PC))
    else note_fail(1, "imem_addr in reset", 32'd0, $sampled(imem_addr), `CORE_RESET_PC);
  a_addr_step: assert property (@(posedge clock_in) disable iff (!rst_n)
    (run_cycles >= 1) |-> (imem_addr == pc_hist[1] + 32'd4))
    else note_fail(2, "fetch step", $sampled(pc_hist[1]), $sampled(imem_addr),
                   $sampled(pc_hist[1]) + 32'd4);
  a_retire_pc: assert property (@(posedge clock_in) disable iff (!rst_n)
    (run_cycles >= 4 && wb.valid) |-> (wb.pc == ret_pc))
    else note_fail(2, "retiring pc", $sampled(ret_pc), $sampled(wb.pc), $sampled(ret_pc));
  a_rtype_result: assert property (@(posedge clock_in) disable iff (!rst_n)
    (run_cycles >= 4 && exp_valid && ret_is_op) |->
      (wb.valid && wb.rd == exp_rd && wb.data == exp_data))
    else note_fail(3, "R-type result", $sampled(ret_pc), $sampled(wb.data),
                   $sampled(exp_data));
  a_imm_result: assert property (@(posedge clock_in) disable iff (!rst_n)
    (run_cycles >= 4 && exp_valid && !ret_is_op) |->
      (wb.valid && wb.rd == exp_rd && wb.data == exp_data))
    else note_fail(4, "immediate result", $sampled(ret_pc), $sampled(wb.data),
                   $sampled(exp_data));
  a_chain_result: assert property (@(posedge clock_in) disable iff (!rst_n)
    (run_cycles >= 4 && exp_valid && ret_pc < CHAIN_BYTES) |-> (wb.data == exp_data))
    else note_fail(5, "chain result", $sampled(ret_pc), $sampled(wb.data),
                   $sampled(exp_data));
  a_no_writeback: assert property (@(posedge clock_in) disable iff (!rst_n)
    (run_cycles >= 4 && !exp_valid) |-> !wb.valid)
    else note_fail(6, "unexpected wb.valid", $sampled(ret_pc), {31'd0, $sampled(wb.valid)},
                   32'd0);

  // --------------------
  // Sequencing
  // --------------------
  task automatic report_test(input int num, input string name);
    tests_run++;
    if (err_cnt[num] != 0) tests_failed++;
    $display("Test %0d, %s: %s, %0d errors", num, name,
             (err_cnt[num] == 0) ? "passed" : "FAILED", err_cnt[num]);
  endtask

  // Wait until the instruction at end_pc sits in WB and all older ones were checked
  task automatic wait_retire(input logic [31:0] end_pc, input int max_cycles, output bit done);
    int n;
    n = 0;
    done = 1'b0;
    while (!done && n < max_cycles) begin
      @(posedge clock_in);
      #1;
      n++;
      done = (run_cycles >= 4) && (ret_pc >= end_pc);
    end
    if (!done)
      $display("Timeout: pc 0x%08h did not reach writeback within %0d cycles",
               end_pc, max_cycles);
  endtask

  task automatic finish_run(input bit completed);
    int total;
    total = 0;
    for (int i = 1; i <= 6; i++) total += err_cnt[i];
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
    if (completed && total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    rst_n = 1'b1;
    build_program();
    #1 rst_n = 1'b0;                  // Edge for the async reset
    repeat (5) @(posedge clock_in);
    #1 rst_n = 1'b1;
    @(posedge clock_in);              // First edge out of reset is checked too
    #1;
    report_test(1, "reset state");
    wait_retire(CHAIN_BYTES, 100, ok);
    if (ok) begin
      report_test(5, "forwarding chains");
      wait_retire(PROG_BYTES, 200, ok);
    end
    if (ok) begin
      report_test(2, "fetch order and retiring pc");
      report_test(3, "R-type results");
      report_test(4, "immediate, LUI and AUIPC results");
      report_test(6, "x0 and unsupported opcodes");
    end
    finish_run(ok);
  end

endmodule

`default_nettype wire

// ==== core_top.f ====
+incdir+common
common/core_pkg.sv
hw/fetch_unit.sv
hw/decode/gpr_file.sv
hw/decode/decode_stage.sv
hw/issue_stage.sv
hw/exec_stage.sv
hw/core_top.sv
verification/tb_core_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_core_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module tb_core_top -f core_top.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
